//--- cpu.f
+incdir+.
cpu_pkg.sv
fwd_if.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu.sv
tb_cpu.sv

//--- cpu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           reset,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,
    output logic           dmem_valid,
    output logic           dmem_write,
    output cpu_pkg::word_t dmem_addr,
    output cpu_pkg::word_t dmem_wdata,
    input  logic           dmem_ready,
    input  cpu_pkg::word_t dmem_rdata
);
    import cpu_pkg::*;

    word_t     if_pc;
    word_t     if_instr;
    logic      fetch_hold;
    logic      redirect;
    word_t     redirect_target;
    logic      mem_busy;
    ctrl_t     ex_ctrl;
    word_t     ex_pc;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    word_t     ex_rs1_data;
    word_t     ex_rs2_data;
    word_t     ex_imm;
    ctrl_t     mem_ctrl;
    word_t     mem_result;
    word_t     mem_store_data;

    fwd_if fwd ();                      // Results flowing back from MEM and WB

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk,
        .reset,
        .fetch_hold,
        .redirect,
        .redirect_target,
        .imem_data,
        .imem_addr,
        .if_pc,
        .if_instr
    );

    decode_stage u_decode (
        .clk,
        .reset,
        .if_pc,
        .if_instr,
        .mem_busy,
        .redirect,
        .fetch_hold,
        .ex_ctrl,
        .ex_pc,
        .ex_rs1,
        .ex_rs2,
        .ex_rs1_data,
        .ex_rs2_data,
        .ex_imm,
        .fwd (fwd)
    );

    execute_stage u_execute (
        .clk,
        .reset,
        .ex_ctrl,
        .ex_pc,
        .ex_rs1,
        .ex_rs2,
        .ex_rs1_data,
        .ex_rs2_data,
        .ex_imm,
        .mem_busy,
        .redirect,
        .redirect_target,
        .mem_ctrl,
        .mem_result,
        .mem_store_data,
        .fwd (fwd)
    );

    memory_stage u_memory (
        .clk,
        .reset,
        .mem_ctrl,
        .mem_result,
        .mem_store_data,
        .dmem_ready,
        .dmem_rdata,
        .dmem_valid,
        .dmem_write,
        .dmem_addr,
        .dmem_wdata,
        .mem_busy,
        .fwd_m  (fwd),
        .fwd_wb (fwd)
    );

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_LINK               // PC+4 for JAL
    } alu_op_e;

    // Decoded controls, carried from ID/EX down to MEM/WB
    typedef struct packed {
        logic      reg_write;       // Never set for rd == x0
        logic      mem_read;
        logic      mem_write;
        logic      is_branch;
        logic      branch_ne;       // BNE when set, BEQ otherwise
        logic      is_jal;
        logic      use_imm;         // Second ALU operand is the immediate
        alu_op_e   alu;
        reg_addr_t rd;
    } ctrl_t;

    localparam word_t NOP_INSTR = 32'h0000_0013;   // addi x0, x0, 0

endpackage

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::word_t     if_pc,
    input  cpu_pkg::word_t     if_instr,
    input  logic               mem_busy,
    input  logic               redirect,
    output logic               fetch_hold,
    output cpu_pkg::ctrl_t     ex_ctrl,
    output cpu_pkg::word_t     ex_pc,
    output cpu_pkg::reg_addr_t ex_rs1,
    output cpu_pkg::reg_addr_t ex_rs2,
    output cpu_pkg::word_t     ex_rs1_data,
    output cpu_pkg::word_t     ex_rs2_data,
    output cpu_pkg::word_t     ex_imm,
    fwd_if.ex_sink             fwd
);
    import cpu_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    ctrl_t      ctrl;
    word_t      imm;
    logic       uses_rs1;
    logic       uses_rs2;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       load_use_stall;

    assign opcode = opcode_e'(if_instr[6:0]);
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];

    always_comb begin
        ctrl     = '0;
        imm      = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu = if_instr[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  ctrl.alu = ALU_SLT;
                    3'b100:  ctrl.alu = ALU_XOR;
                    3'b110:  ctrl.alu = ALU_OR;
                    3'b111:  ctrl.alu = ALU_AND;
                    default: ctrl.reg_write = 1'b0;        // Outside the subset
                endcase
            end
            OPC_OP_IMM: begin
                ctrl.reg_write = (funct3 == 3'b000);      // ADDI only
                ctrl.use_imm   = 1'b1;
                uses_rs1       = 1'b1;
                imm            = {{20{if_instr[31]}}, if_instr[31:20]};
            end
            OPC_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
                uses_rs1       = 1'b1;
                imm            = {{20{if_instr[31]}}, if_instr[31:20]};
            end
            OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
                imm            = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            end
            OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = funct3[0];
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
                imm            = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                                  if_instr[30:25], if_instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jal    = 1'b1;
                ctrl.alu       = ALU_PASS_LINK;
                imm            = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                                  if_instr[20], if_instr[30:21], 1'b0};
            end
            default: ctrl = '0;                           // Unknown opcode acts as a NOP
        endcase
        ctrl.rd = if_instr[11:7];
        if (ctrl.rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    register_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .fwd      (fwd)
    );

    // Load in EX whose result the instruction in decode needs
    assign load_use_stall = ex_ctrl.mem_read && ex_ctrl.reg_write &&
                            ((uses_rs1 && rs1 == ex_ctrl.rd) ||
                             (uses_rs2 && rs2 == ex_ctrl.rd));
    assign fetch_hold     = load_use_stall || mem_busy;

    // ID/EX control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_ctrl <= '0;
        end else if (!mem_busy) begin
            if (redirect || load_use_stall) begin
                ex_ctrl <= '0;                            // Bubble
            end else begin
                ex_ctrl <= ctrl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            ex_pc       <= if_pc;
            ex_rs1      <= uses_rs1 ? rs1 : '0;           // Unused sources never forward
            ex_rs2      <= uses_rs2 ? rs2 : '0;
            ex_rs1_data <= rs1_data;
            ex_rs2_data <= rs2_data;
            ex_imm      <= imm;
        end
    end

    a_stall_vs_redirect: assert property (@(posedge clk) disable iff (reset)
        !(load_use_stall && redirect));

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::ctrl_t     ex_ctrl,
    input  cpu_pkg::word_t     ex_pc,
    input  cpu_pkg::reg_addr_t ex_rs1,
    input  cpu_pkg::reg_addr_t ex_rs2,
    input  cpu_pkg::word_t     ex_rs1_data,
    input  cpu_pkg::word_t     ex_rs2_data,
    input  cpu_pkg::word_t     ex_imm,
    input  logic               mem_busy,
    output logic               redirect,
    output cpu_pkg::word_t     redirect_target,
    output cpu_pkg::ctrl_t     mem_ctrl,
    output cpu_pkg::word_t     mem_result,
    output cpu_pkg::word_t     mem_store_data,
    fwd_if.ex_sink             fwd
);
    import cpu_pkg::*;

    logic  m_fwd_ok;
    logic  a_from_mem;
    logic  a_from_wb;
    logic  b_from_mem;
    logic  b_from_wb;
    word_t op_a;
    word_t rs2_val;
    word_t op_b;
    word_t alu_result;
    logic  branch_taken;

    // A load in MEM has only its address, the load-use stall covers that case
    assign m_fwd_ok   = fwd.m_write && !fwd.m_is_load;
    assign a_from_mem = m_fwd_ok && (fwd.m_rd == ex_rs1);
    assign a_from_wb  = fwd.wb_write && (fwd.wb_rd == ex_rs1);
    assign b_from_mem = m_fwd_ok && (fwd.m_rd == ex_rs2);
    assign b_from_wb  = fwd.wb_write && (fwd.wb_rd == ex_rs2);

    assign op_a    = a_from_mem ? fwd.m_value :
                     a_from_wb  ? fwd.wb_value : ex_rs1_data;
    assign rs2_val = b_from_mem ? fwd.m_value :
                     b_from_wb  ? fwd.wb_value : ex_rs2_data;
    assign op_b    = ex_ctrl.use_imm ? ex_imm : rs2_val;

    always_comb begin
        case (ex_ctrl.alu)
            ALU_ADD:       alu_result = op_a + op_b;
            ALU_SUB:       alu_result = op_a - op_b;
            ALU_AND:       alu_result = op_a & op_b;
            ALU_OR:        alu_result = op_a | op_b;
            ALU_XOR:       alu_result = op_a ^ op_b;
            ALU_SLT:       alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_LINK: alu_result = ex_pc + 32'd4;     // JAL link value
            default:       alu_result = op_a + op_b;
        endcase
    end

    assign branch_taken    = ex_ctrl.is_branch && ((op_a == rs2_val) != ex_ctrl.branch_ne);
    assign redirect        = (branch_taken || ex_ctrl.is_jal) && !mem_busy;
    assign redirect_target = ex_pc + ex_imm;

    // EX/MEM register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_ctrl <= '0;
        end else if (!mem_busy) begin
            mem_ctrl <= ex_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            mem_result     <= alu_result;       // Also the data address
            mem_store_data <= rs2_val;
        end
    end

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           fetch_hold,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_target,
    input  cpu_pkg::word_t imem_data,
    output cpu_pkg::word_t imem_addr,
    output cpu_pkg::word_t if_pc,
    output cpu_pkg::word_t if_instr
);
    import cpu_pkg::*;

    word_t pc;
    word_t pc_next;

    always_comb begin
        if (redirect) begin
            pc_next = redirect_target;      // Taken branch or JAL in EX
        end else if (fetch_hold) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign imem_addr = pc;              // Combinational instruction read

    // IF/ID register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_pc    <= RESET_PC;
            if_instr <= NOP_INSTR;
        end else if (redirect) begin
            if_instr <= NOP_INSTR;      // Squash the wrong-path fetch
        end else if (!fetch_hold) begin
            if_pc    <= pc;
            if_instr <= imem_data;
        end
    end

endmodule

`default_nettype wire

//--- fwd_if.sv
`timescale 1ns/10ps
`default_nettype none

interface fwd_if;
    import cpu_pkg::*;

    reg_addr_t m_rd;            // EX/MEM destination
    logic      m_write;
    word_t     m_value;         // EX/MEM ALU result
    logic      m_is_load;       // Value not ready yet for a load

    reg_addr_t wb_rd;
    logic      wb_write;
    word_t     wb_value;

    modport mem_src (output m_rd, m_write, m_value, m_is_load);
    modport wb_src  (output wb_rd, wb_write, wb_value);
    modport ex_sink (input m_rd, m_write, m_value, m_is_load, wb_rd, wb_write, wb_value);

endinterface

`default_nettype wire

//--- memory_stage.sv
`timescale 1ns/10ps
`default_nettype none

module memory_stage (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::ctrl_t mem_ctrl,
    input  cpu_pkg::word_t mem_result,
    input  cpu_pkg::word_t mem_store_data,
    input  logic           dmem_ready,
    input  cpu_pkg::word_t dmem_rdata,
    output logic           dmem_valid,
    output logic           dmem_write,
    output cpu_pkg::word_t dmem_addr,
    output cpu_pkg::word_t dmem_wdata,
    output logic           mem_busy,
    fwd_if.mem_src         fwd_m,
    fwd_if.wb_src          fwd_wb
);
    import cpu_pkg::*;

    word_t wb_data;

    // Request straight from EX/MEM, which holds until the transfer
    assign dmem_valid = mem_ctrl.mem_read || mem_ctrl.mem_write;
    assign dmem_write = mem_ctrl.mem_write;
    assign dmem_addr  = mem_result;
    assign dmem_wdata = mem_store_data;
    assign mem_busy   = dmem_valid && !dmem_ready;

    assign fwd_m.m_rd      = mem_ctrl.rd;
    assign fwd_m.m_write   = mem_ctrl.reg_write;
    assign fwd_m.m_value   = mem_result;
    assign fwd_m.m_is_load = mem_ctrl.mem_read;

    assign wb_data = mem_ctrl.mem_read ? dmem_rdata : mem_result;   // rdata valid at transfer

    // MEM/WB also holds during a stall so a waiting EX keeps its WB forward
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fwd_wb.wb_write <= 1'b0;
        end else if (!mem_busy) begin
            fwd_wb.wb_write <= mem_ctrl.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            fwd_wb.wb_rd    <= mem_ctrl.rd;
            fwd_wb.wb_value <= wb_data;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_addr) &&
                                      $stable(dmem_wdata) && $stable(dmem_write));

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::word_t     rs1_data,
    output cpu_pkg::word_t     rs2_data,
    fwd_if.ex_sink             fwd
);
    import cpu_pkg::*;

    word_t regs [1:31];                 // x0 has no storage

    always_ff @(posedge clk) begin
        if (fwd.wb_write && fwd.wb_rd != '0) begin
            regs[fwd.wb_rd] <= fwd.wb_value;
        end
    end

    // Write-first, so decode sees the value retiring this cycle
    assign rs1_data = (rs1 == '0) ? '0 :
                      (fwd.wb_write && fwd.wb_rd == rs1) ? fwd.wb_value : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (fwd.wb_write && fwd.wb_rd == rs2) ? fwd.wb_value : regs[rs2];

    // Decode drops x0 writes long before they reach WB
    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        fwd.wb_write |-> fwd.wb_rd != '0);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build the cpu testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f cpu.f --top-module tb_cpu -o tb_cpu; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/tb_cpu 2>&1); then
    echo "$output"
    echo "Simulation exited with an error"
    exit 1
fi
echo "$output"

if echo "$output" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1

//--- tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Instruction kinds of the generated programs
localparam int K_ALU    = 0;
localparam int K_ADDI   = 1;
localparam int K_LW     = 2;
localparam int K_SW     = 3;
localparam int K_BRANCH = 4;
localparam int K_JAL    = 5;

function automatic word_t next_random();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 16;                          // Upper bits, low ones cycle too fast
endfunction

function automatic word_t fill_value(int index);
    return 32'h5a00_0000 + word_t'(index) * 32'h0003_0007;
endfunction

// fn selects ADD, SUB, AND, OR, XOR, SLT in that order
function automatic word_t rtype_word(int fn, int rs2, int rs1, int rd);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = (fn == 1) ? 7'b0100000 : 7'b0000000;
    case (fn)
        2:       f3 = 3'b111;
        3:       f3 = 3'b110;
        4:       f3 = 3'b100;
        5:       f3 = 3'b010;
        default: f3 = 3'b000;
    endcase
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
endfunction

function automatic word_t itype_word(int imm, int rs1, logic [2:0] f3, int rd,
                                     logic [6:0] opc);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
endfunction

function automatic word_t stype_word(int imm, int rs2, int rs1);
    logic [11:0] v;
    v = 12'(imm);
    return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], 7'b0100011};
endfunction

function automatic word_t btype_word(int imm, int rs2, int rs1, logic ne);
    logic [12:0] v;
    v = 13'(imm);
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), 2'b00, ne, v[4:1], v[11], 7'b1100011};
endfunction

function automatic word_t jtype_word(int imm, int rd);
    logic [20:0] v;
    v = 21'(imm);
    return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
endfunction

// Instruction mix of each test, r runs from 0 to 7
function automatic int pick_kind(int test, int r);
    case (test)
        0:       return (r < 4) ? K_ALU : (r < 6) ? K_ADDI : K_SW;
        1:       return (r < 3) ? K_LW : (r < 5) ? K_ALU : (r < 6) ? K_ADDI : K_SW;
        2:       return (r < 2) ? K_BRANCH : (r < 3) ? K_JAL : (r < 5) ? K_ALU :
                        (r < 6) ? K_ADDI : K_SW;
        default: return (r < 2) ? K_ALU : (r < 3) ? K_ADDI : (r < 4) ? K_LW :
                        (r < 6) ? K_SW : (r < 7) ? K_BRANCH : K_JAL;
    endcase
endfunction

function automatic void build_program(int test);
    int skip;
    for (int i = 0; i < PROG_LEN; i++) begin
        p_rd[i]  = 1 + int'(next_random() % 7);   // x1..x7 keeps hazards frequent
        p_rs1[i] = int'(next_random() % 8);
        p_rs2[i] = int'(next_random() % 8);
        p_fn[i]  = int'(next_random() % 6);
        p_imm[i] = int'(next_random() % 4096) - 2048;
        if (i < 7) begin
            p_kind[i] = K_ADDI;                   // Prologue sets x1..x7
            p_rd[i]   = i + 1;
            p_rs1[i]  = 0;
        end else if (i == PROG_LEN - 1) begin
            p_kind[i] = K_JAL;                    // Jump to itself
            p_rd[i]   = 0;
            p_imm[i]  = 0;
        end else begin
            p_kind[i] = pick_kind(test, int'(next_random() % 8));
            if (next_random() % 8 == 0) begin
                p_rd[i] = 0;
            end
        end
        if (p_kind[i] == K_LW || p_kind[i] == K_SW) begin
            p_rs1[i] = 0;                         // Base x0, word offsets
            p_imm[i] = 4 * int'(next_random() % DMEM_WORDS);
        end
        if ((p_kind[i] == K_BRANCH || p_kind[i] == K_JAL) && i < PROG_LEN - 1) begin
            skip = 1 + int'(next_random() % 3);
            if (i + skip > PROG_LEN - 1) begin
                skip = PROG_LEN - 1 - i;
            end
            p_imm[i] = 4 * skip;                  // Forward only
        end
        case (p_kind[i])
            K_ALU:    imem[i] = rtype_word(p_fn[i], p_rs2[i], p_rs1[i], p_rd[i]);
            K_ADDI:   imem[i] = itype_word(p_imm[i], p_rs1[i], 3'b000, p_rd[i], 7'b0010011);
            K_LW:     imem[i] = itype_word(p_imm[i], p_rs1[i], 3'b010, p_rd[i], 7'b0000011);
            K_SW:     imem[i] = stype_word(p_imm[i], p_rs2[i], p_rs1[i]);
            K_BRANCH: imem[i] = btype_word(p_imm[i], p_rs2[i], p_rs1[i], p_fn[i][0]);
            default:  imem[i] = jtype_word(p_imm[i], p_rd[i]);
        endcase
    end
endfunction

// Runs the program on the instruction-set model and lists the stores
function automatic void run_reference();
    int    pc;
    int    next;
    logic  writes;
    word_t a;
    word_t b;
    word_t res;
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < 8; i++) begin
        m_regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        m_mem[i] = fill_value(i);
    end
    pc = 0;
    while (pc < PROG_LEN - 1) begin
        a      = m_regs[p_rs1[pc]];
        b      = m_regs[p_rs2[pc]];
        res    = '0;
        writes = 1'b1;
        next   = pc + 1;
        case (p_kind[pc])
            K_ALU: begin
                case (p_fn[pc])
                    0:       res = a + b;
                    1:       res = a - b;
                    2:       res = a & b;
                    3:       res = a | b;
                    4:       res = a ^ b;
                    default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                endcase
            end
            K_ADDI:   res = a + word_t'(p_imm[pc]);
            K_LW:     res = m_mem[p_imm[pc] / 4];
            K_SW: begin
                writes = 1'b0;
                m_mem[p_imm[pc] / 4] = b;
                exp_addr.push_back(word_t'(p_imm[pc]));
                exp_data.push_back(b);
            end
            K_BRANCH: begin
                writes = 1'b0;
                if ((a == b) != p_fn[pc][0]) begin
                    next = pc + p_imm[pc] / 4;
                end
            end
            default: begin
                res  = RESET_PC + word_t'(4 * pc + 4);     // Link value
                next = pc + p_imm[pc] / 4;
            end
        endcase
        if (writes && p_rd[pc] != 0) begin
            m_regs[p_rd[pc]] = res;
        end
        pc = next;
    end
endfunction

`endif

//--- tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam word_t RESET_PC     = 32'h0000_0100;
    localparam int    NUM_TESTS    = 4;
    localparam int    PROG_LEN     = 48;
    localparam int    DMEM_WORDS   = 64;
    localparam int    RESET_CYCLES = 16;
    localparam int    DRAIN_CYCLES = 4;
    // 20 cycles per instruction, plus reset and drain of each test
    localparam int    MAX_CYCLES   = NUM_TESTS * (20 * PROG_LEN + RESET_CYCLES + DRAIN_CYCLES);

    logic  clk;
    logic  reset;
    word_t imem_addr;
    word_t imem_data;
    logic  dmem_valid;
    logic  dmem_write;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_ready;
    word_t dmem_rdata;

    word_t seed;
    word_t imem [0:PROG_LEN-1];
    word_t dmem [0:DMEM_WORDS-1];
    int    p_kind [0:PROG_LEN-1];
    int    p_rd [0:PROG_LEN-1];
    int    p_rs1 [0:PROG_LEN-1];
    int    p_rs2 [0:PROG_LEN-1];
    int    p_fn [0:PROG_LEN-1];
    int    p_imm [0:PROG_LEN-1];
    word_t m_regs [0:7];
    word_t m_mem [0:DMEM_WORDS-1];
    word_t exp_addr [$];
    word_t exp_data [$];

    string test_name;
    int    store_count;
    int    test_errors;
    int    total_errors;
    int    tests_failed;
    int    cycle_count;
    int    wait_left;                   // Cycles the current request still waits
    int    fetch_index;
    logic  held;
    logic  held_write;
    word_t held_addr;
    word_t held_data;
    logic  s_valid;                     // Bus as seen mid-cycle
    logic  s_ready;
    logic  s_write;
    word_t s_addr;
    word_t s_wdata;

    `include "tb_model.svh"

    cpu #(
        .RESET_PC (RESET_PC)
    ) u_dut (
        .clk,
        .reset,
        .imem_addr,
        .imem_data,
        .dmem_valid,
        .dmem_write,
        .dmem_addr,
        .dmem_wdata,
        .dmem_ready,
        .dmem_rdata
    );

    always #50 clk = ~clk;

    // Both memories answer reads combinationally
    assign fetch_index = int'((imem_addr - RESET_PC) >> 2);
    assign imem_data   = (fetch_index < PROG_LEN) ? imem[fetch_index] : NOP_INSTR;
    assign dmem_rdata  = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic string test_label(int test);
        case (test)
            0:       return "alu_chain";
            1:       return "load_use";
            2:       return "branch_jal";
            default: return "mixed";
        endcase
    endfunction

    task automatic check_store(input word_t addr, input word_t data);
        if (store_count >= exp_addr.size()) begin
            $display("%s: extra store to %h with data %h", test_name, addr, data);
            test_errors++;
        end else begin
            if (addr !== exp_addr[store_count]) begin
                $display("MISMATCH %s store %0d address expected %h actual %h", test_name,
                         store_count, exp_addr[store_count], addr);
                test_errors++;
            end
            if (data !== exp_data[store_count]) begin
                $display("MISMATCH %s store %0d data expected %h actual %h", test_name,
                         store_count, exp_data[store_count], data);
                test_errors++;
            end
        end
        store_count++;
    endtask

    always @(negedge clk) begin
        s_valid = dmem_valid;
        s_ready = dmem_ready;
        s_write = dmem_write;
        s_addr  = dmem_addr;
        s_wdata = dmem_wdata;
    end

    // Data memory with 0 to 3 wait cycles per request
    always @(posedge clk) begin
        if (held && (!s_valid || s_addr !== held_addr || s_wdata !== held_data ||
                     s_write !== held_write)) begin
            $display("%s: data request changed while dmem_ready was low", test_name);
            test_errors++;
        end
        if (s_valid && s_ready) begin
            if (s_write) begin
                check_store(s_addr, s_wdata);
                dmem[s_addr[7:2]] = s_wdata;
            end
            wait_left = int'(next_random() % 4);
        end else if (s_valid) begin
            wait_left = wait_left - 1;
        end
        held       = s_valid && !s_ready;
        held_write = s_write;
        held_addr  = s_addr;
        held_data  = s_wdata;
        dmem_ready <= (wait_left == 0);
    end

    task automatic run_test(input int test);
        int    visits;
        logic  at_last;
        word_t last_addr;
        last_addr = RESET_PC + word_t'(4 * (PROG_LEN - 1));
        test_name = test_label(test);
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        build_program(test);
        run_reference();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_value(i);
        end
        store_count = 0;
        test_errors = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);                                 // First cycle out of reset
        if (imem_addr !== RESET_PC) begin
            $display("MISMATCH %s reset fetch address expected %h actual %h", test_name,
                     RESET_PC, imem_addr);
            test_errors++;
        end
        if (dmem_valid !== 1'b0) begin
            $display("MISMATCH %s reset dmem_valid expected 0 actual %b", test_name,
                     dmem_valid);
            test_errors++;
        end
        // Third arrival at the final JAL means it has looped at least once
        visits  = 0;
        at_last = 1'b0;
        while (visits < 3) begin
            @(negedge clk);
            if (imem_addr == last_addr && !at_last) begin
                visits++;
            end
            at_last = (imem_addr == last_addr);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (store_count < exp_addr.size()) begin
            $display("%s: only %0d of %0d expected stores reached data memory", test_name,
                     store_count, exp_addr.size());
            test_errors++;
        end
        if (test_errors != 0) begin
            tests_failed++;
            $display("Test %s failed with %0d errors", test_name, test_errors);
        end else begin
            $display("Test %s ok, %0d stores checked", test_name, store_count);
        end
        total_errors += test_errors;
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        dmem_ready   = 1'b1;
        seed         = 32'hf04;
        wait_left    = 0;
        held         = 1'b0;
        s_valid      = 1'b0;
        s_ready      = 1'b1;
        cycle_count  = 0;
        total_errors = 0;
        tests_failed = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests run %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        wait (cycle_count > MAX_CYCLES);
        $display("Timeout after %0d cycles, the CPU never reached the end of a test",
                 MAX_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
